/* tests/data_mem_trace.txt */
// op: bit0 read_en, bit1 write_en, bit2 stray write while busy
// columns: op funct3 address store_data expected_load (hex)
2 2 00000000 11223344 00000000
1 2 00000000 00000000 11223344
2 2 00001004 a5b6c7d8 00000000
1 2 00000004 00000000 a5b6c7d8
1 2 0000f004 00000000 a5b6c7d8
2 2 00000008 8a7ff501 00000000
1 0 00000008 00000000 00000001
1 0 00000009 00000000 fffffff5
1 0 0000000a 00000000 0000007f
1 0 0000000b 00000000 ffffff8a
1 4 00000009 00000000 000000f5
1 4 0000000b 00000000 0000008a
1 1 00000008 00000000 fffff501
1 1 0000000a 00000000 ffff8a7f
1 1 00000009 00000000 fffff501
1 5 0000000b 00000000 00008a7f
1 2 0000000a 00000000 8a7ff501
2 2 0000000c 76543210 00000000
2 0 0000000d ffffffab 00000000
1 2 0000000c 00000000 7654ab10
2 0 0000000f 12345699 00000000
1 2 0000000c 00000000 9954ab10
2 0 0000000c 000000ee 00000000
2 0 0000000e 0000005c 00000000
1 2 0000000c 00000000 995cabee
2 1 0000000e dead1234 00000000
1 2 0000000c 00000000 1234abee
2 1 0000000d 0000cafe 00000000
1 2 0000000c 00000000 1234cafe
3 2 0000000c ffffffff 1234cafe
3 4 0000000f 00000000 00000012
1 2 0000000c 00000000 1234cafe
1 3 00000000 00000000 00000000
2 4 0000000c 00000000 00000000
1 6 00000008 00000000 00000000
1 2 0000000c 00000000 1234cafe
5 2 00000000 00000000 11223344
6 2 00000010 0badf00d 00000000
1 2 00000010 00000000 0badf00d
6 0 00000011 00000077 00000000
1 2 00000010 00000000 0bad770d
1 2 00000000 00000000 11223344

/* files.f */
source/mem_pkg.sv
source/word_ram.sv
source/load_align.sv
source/store_merge.sv
source/data_mem_ctrl.sv
source/data_mem_top.sv
tests/data_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the data memory testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the testbench reports failure.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=data_mem_sim

verilator --binary -Wno-fatal --top-module data_mem_tb -f files.f \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

/* tests/data_mem_tb.sv */
`default_nettype none

module data_mem_tb;

    localparam int DATA_WIDTH   = mem_pkg::DEFAULT_DATA_WIDTH;
    localparam int ADDR_WIDTH   = mem_pkg::DEFAULT_ADDR_WIDTH;
    localparam int MEMORY_DEPTH = 1024;
    localparam int RAM_LATENCY  = 2;
    localparam int BYTE_BITS    = $clog2(MEMORY_DEPTH) + 2;
    localparam int MODEL_BYTES  = MEMORY_DEPTH * 4;
    localparam int MAX_RECORDS  = 64;
    localparam int RECORD_WORDS = 5;
    localparam int RANDOM_REQS  = 200;
    localparam int RAND_SEED    = 65423;
    localparam int POOL_WORDS   = 16;
    // Random traffic stays in the upper half, away from the trace words
    localparam int POOL_BASE    = MODEL_BYTES / 2;

    logic                  clk;
    logic                  rstN;
    logic                  read_en;
    logic                  write_en;
    logic [2:0]            funct3;
    logic [ADDR_WIDTH-1:0] address;
    logic [DATA_WIDTH-1:0] data_in;
    logic [DATA_WIDTH-1:0] data_out;
    logic                  ready;

    // Five words per request: op, funct3, address, store data, expected load
    logic [31:0] trace_mem [RECORD_WORDS*MAX_RECORDS];
    // Byte-wide reference memory, indexed by the wrapped byte address
    logic [7:0]  ref_mem [MODEL_BYTES];
    logic        pool_written [POOL_WORDS];
    logic [31:0] last_out;
    int          num_records;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    data_mem_top #(
        .DATA_WIDTH   (DATA_WIDTH),
        .ADDR_WIDTH   (ADDR_WIDTH),
        .MEMORY_DEPTH (MEMORY_DEPTH),
        .RAM_LATENCY  (RAM_LATENCY)
    ) uut (
        .clk      (clk),
        .rstN     (rstN),
        .read_en  (read_en),
        .write_en (write_en),
        .funct3   (funct3),
        .address  (address),
        .data_in  (data_in),
        .data_out (data_out),
        .ready    (ready)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("sim failed");
            $fatal(1, "Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, actual,
                     expected);
            $display("sim failed");
            $fatal(1, "Stopped at the first wrong value");
        end
    endtask

    // 0 for a request that is never accepted, 1 for a load, 2 for a store
    function automatic int request_kind(input logic rd, input logic wr, input logic [2:0] f3);
        if (rd) begin
            case (f3)
                mem_pkg::FUNCT3_B, mem_pkg::FUNCT3_H, mem_pkg::FUNCT3_W,
                mem_pkg::FUNCT3_BU, mem_pkg::FUNCT3_HU: return 1;
                default: return 0;
            endcase
        end
        if (wr) begin
            case (f3)
                mem_pkg::FUNCT3_B, mem_pkg::FUNCT3_H, mem_pkg::FUNCT3_W: return 2;
                default: return 0;
            endcase
        end
        return 0;
    endfunction

    function automatic logic [31:0] model_load(input logic [2:0] f3, input logic [31:0] addr);
        logic [BYTE_BITS-3:0] word_idx;
        logic [7:0]           byte_val;
        logic [15:0]          half_val;
        logic [31:0]          word_val;
        word_idx = addr[BYTE_BITS-1:2];
        byte_val = ref_mem[{word_idx, addr[1:0]}];
        half_val = {ref_mem[{word_idx, addr[1], 1'b1}], ref_mem[{word_idx, addr[1], 1'b0}]};
        word_val = {ref_mem[{word_idx, 2'd3}], ref_mem[{word_idx, 2'd2}],
                    ref_mem[{word_idx, 2'd1}], ref_mem[{word_idx, 2'd0}]};
        case (f3)
            mem_pkg::FUNCT3_B:  return {{24{byte_val[7]}}, byte_val};
            mem_pkg::FUNCT3_BU: return {24'd0, byte_val};
            mem_pkg::FUNCT3_H:  return {{16{half_val[15]}}, half_val};
            mem_pkg::FUNCT3_HU: return {16'd0, half_val};
            default:            return word_val;
        endcase
    endfunction

    task automatic model_store(input logic [2:0] f3, input logic [31:0] addr,
                               input logic [31:0] wdata);
        logic [BYTE_BITS-3:0] word_idx;
        word_idx = addr[BYTE_BITS-1:2];
        case (f3)
            mem_pkg::FUNCT3_B: begin
                ref_mem[{word_idx, addr[1:0]}] = wdata[7:0];
            end
            mem_pkg::FUNCT3_H: begin
                ref_mem[{word_idx, addr[1], 1'b0}] = wdata[7:0];
                ref_mem[{word_idx, addr[1], 1'b1}] = wdata[15:8];
            end
            default: begin
                ref_mem[{word_idx, 2'd0}] = wdata[7:0];
                ref_mem[{word_idx, 2'd1}] = wdata[15:8];
                ref_mem[{word_idx, 2'd2}] = wdata[23:16];
                ref_mem[{word_idx, 2'd3}] = wdata[31:24];
            end
        endcase
    endtask

    // Called at a falling edge
    task automatic wait_ready();
        while (ready !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    // Optionally drives a stray full-word write for one edge while the DUT is busy
    task automatic issue_request(input logic rd, input logic wr, input logic [2:0] f3,
                                 input logic [31:0] addr, input logic [31:0] wdata,
                                 input logic noise);
        @(posedge clk);
        read_en  <= rd;
        write_en <= wr;
        funct3   <= f3;
        address  <= addr;
        data_in  <= wdata;
        // Accept edge
        @(posedge clk);
        if (noise) begin
            read_en  <= 1'b0;
            write_en <= 1'b1;
            funct3   <= mem_pkg::FUNCT3_W;
            data_in  <= ~wdata;
        end else begin
            read_en  <= 1'b0;
            write_en <= 1'b0;
        end
        @(negedge clk);
        check_value(32'(ready), 32'd0, "ready still high after a valid request");
        if (noise) begin
            @(posedge clk);
            read_en  <= 1'b0;
            write_en <= 1'b0;
            @(negedge clk);
        end
        wait_ready();
    endtask

    task automatic issue_ignored(input logic rd, input logic wr, input logic [2:0] f3,
                                 input logic [31:0] addr, input logic [31:0] wdata);
        @(posedge clk);
        read_en  <= rd;
        write_en <= wr;
        funct3   <= f3;
        address  <= addr;
        data_in  <= wdata;
        repeat (3) begin
            @(negedge clk);
            check_value(32'(ready), 32'd1, "ready dropped for a reserved access code");
            check_value(data_out, last_out, "data_out changed on a reserved access code");
        end
        @(posedge clk);
        read_en  <= 1'b0;
        write_en <= 1'b0;
        @(negedge clk);
    endtask

    task automatic run_access(input logic rd, input logic wr, input logic [2:0] f3,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              input logic noise, input logic [31:0] trace_expected,
                              input logic use_trace);
        int          kind;
        logic [31:0] model_value;
        kind = request_kind(rd, wr, f3);
        if (kind == 0) begin
            issue_ignored(rd, wr, f3, addr, wdata);
        end else begin
            issue_request(rd, wr, f3, addr, wdata, noise);
            if (kind == 1) begin
                model_value = model_load(f3, addr);
                if (use_trace) begin
                    check_value(data_out, trace_expected, "load result from the trace");
                end
                check_value(data_out, model_value, "load result against the model");
                last_out = model_value;
            end else begin
                model_store(f3, addr, wdata);
                check_value(data_out, last_out, "data_out changed during a store");
            end
        end
    endtask

    initial begin
        logic [31:0] seed_draw;
        logic [31:0] rand_addr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expect_val;
        logic [2:0]  op;
        logic [2:0]  f3;
        logic [1:0]  lane;
        logic        rd;
        logic        wr;
        logic        noise;
        int          base;
        int          kind;
        int          slot;

        clk      = 1'b0;
        rstN     = 1'b0;
        read_en  = 1'b0;
        write_en = 1'b0;
        funct3   = 3'd0;
        address  = '0;
        data_in  = '0;
        last_out = '0;
        seed_draw = $urandom(RAND_SEED);

        for (int i = 0; i < RECORD_WORDS * MAX_RECORDS; i++) begin
            trace_mem[i] = '0;
        end
        for (int i = 0; i < POOL_WORDS; i++) begin
            pool_written[i] = 1'b0;
        end
        $readmemh("tests/data_mem_trace.txt", trace_mem);
        // An op of zero marks the end of the trace
        num_records = 0;
        while (num_records < MAX_RECORDS && trace_mem[num_records * RECORD_WORDS] != 0) begin
            num_records++;
        end
        if (num_records == 0) begin
            $display("sim failed");
            $fatal(1, "No requests could be read from tests/data_mem_trace.txt");
        end
        cycle_limit = (num_records + RANDOM_REQS) * (RAM_LATENCY + 4) + 100;

        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        check_value(32'(ready), 32'd1, "ready after reset");
        check_value(data_out, 32'd0, "data_out after reset");

        for (int r = 0; r < num_records; r++) begin
            base       = r * RECORD_WORDS;
            op         = trace_mem[base][2:0];
            f3         = trace_mem[base+1][2:0];
            addr       = trace_mem[base+2];
            wdata      = trace_mem[base+3];
            expect_val = trace_mem[base+4];
            run_access(op[0], op[1], f3, addr, wdata, op[2], expect_val, 1'b1);
        end

        for (int n = 0; n < RANDOM_REQS; n++) begin
            kind      = int'($urandom % 8);
            slot      = int'($urandom % POOL_WORDS);
            lane      = 2'($urandom);
            rand_addr = $urandom;
            wdata     = $urandom;
            noise     = ($urandom % 4) == 0;
            // Sub-word stores and loads need a word that holds known data
            if (!pool_written[slot]) begin
                kind = 7;
            end
            // High bits are random so every access also exercises the wrap
            addr = (rand_addr & ~32'(MODEL_BYTES - 1)) | 32'(POOL_BASE + slot * 4) | 32'(lane);
            rd = 1'b0;
            wr = 1'b1;
            case (kind)
                0: f3 = mem_pkg::FUNCT3_B;
                1: f3 = mem_pkg::FUNCT3_H;
                2: f3 = mem_pkg::FUNCT3_W;
                3: f3 = mem_pkg::FUNCT3_BU;
                4: f3 = mem_pkg::FUNCT3_HU;
                5: f3 = mem_pkg::FUNCT3_B;
                6: f3 = mem_pkg::FUNCT3_H;
                default: f3 = mem_pkg::FUNCT3_W;
            endcase
            if (kind < 5) begin
                rd = 1'b1;
                wr = 1'($urandom);
            end
            run_access(rd, wr, f3, addr, wdata, noise, 32'd0, 1'b0);
            if (kind == 7) begin
                pool_written[slot] = 1'b1;
            end
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* source/data_mem_top.sv */
`default_nettype none

module data_mem_top #(
    parameter int DATA_WIDTH   = mem_pkg::DEFAULT_DATA_WIDTH,
    parameter int ADDR_WIDTH   = mem_pkg::DEFAULT_ADDR_WIDTH,
    parameter int MEMORY_DEPTH = 1024,
    parameter int RAM_LATENCY  = 2
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  read_en,
    input  logic                  write_en,
    input  logic [2:0]            funct3,
    input  logic [ADDR_WIDTH-1:0] address,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  ready
);

    localparam int INDEX_WIDTH = $clog2(MEMORY_DEPTH);

    logic                  ram_read;
    logic                  ram_write;
    logic [ADDR_WIDTH-3:0] ram_index;
    logic [DATA_WIDTH-1:0] ram_wdata;
    logic [DATA_WIDTH-1:0] ram_rdata;
    mem_pkg::access_t      access;
    logic [1:0]            lane;
    logic [DATA_WIDTH-1:0] store_word;
    logic [DATA_WIDTH-1:0] aligned;
    logic [DATA_WIDTH-1:0] merged;

    data_mem_ctrl #(
        .DATA_WIDTH  (DATA_WIDTH),
        .ADDR_WIDTH  (ADDR_WIDTH),
        .RAM_LATENCY (RAM_LATENCY)
    ) u_ctrl (
        .clk        (clk),
        .rstN       (rstN),
        .read_en    (read_en),
        .write_en   (write_en),
        .funct3     (funct3),
        .address    (address),
        .data_in    (data_in),
        .ram_rdata  (ram_rdata),
        .aligned    (aligned),
        .merged     (merged),
        .ready      (ready),
        .data_out   (data_out),
        .ram_read   (ram_read),
        .ram_write  (ram_write),
        .ram_index  (ram_index),
        .ram_wdata  (ram_wdata),
        .access     (access),
        .lane       (lane),
        .store_word (store_word)
    );

    // Upper word index bits are dropped, so the RAM repeats across the address space
    word_ram #(
        .DATA_WIDTH   (DATA_WIDTH),
        .MEMORY_DEPTH (MEMORY_DEPTH),
        .RAM_LATENCY  (RAM_LATENCY)
    ) u_ram (
        .clk       (clk),
        .ram_read  (ram_read),
        .ram_write (ram_write),
        .ram_index (ram_index[INDEX_WIDTH-1:0]),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    // Both lane blocks work on the word coming out of the RAM
    load_align u_load_align (
        .access (access),
        .lane   (lane),
        .word   (ram_rdata),
        .result (aligned)
    );

    store_merge u_store_merge (
        .access     (access),
        .lane       (lane),
        .old_word   (ram_rdata),
        .store_data (store_word),
        .merged     (merged)
    );

endmodule

`default_nettype wire

/* source/data_mem_ctrl.sv */
`default_nettype none

module data_mem_ctrl #(
    parameter int DATA_WIDTH  = 32,
    parameter int ADDR_WIDTH  = 32,
    parameter int RAM_LATENCY = 2
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  read_en,
    input  logic                  write_en,
    input  logic [2:0]            funct3,
    input  logic [ADDR_WIDTH-1:0] address,
    input  logic [DATA_WIDTH-1:0] data_in,
    input  logic [DATA_WIDTH-1:0] ram_rdata,
    input  logic [DATA_WIDTH-1:0] aligned,
    input  logic [DATA_WIDTH-1:0] merged,
    output logic                  ready,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  ram_read,
    output logic                  ram_write,
    output logic [ADDR_WIDTH-3:0] ram_index,
    output logic [DATA_WIDTH-1:0] ram_wdata,
    output mem_pkg::access_t      access,
    output logic [1:0]            lane,
    output logic [DATA_WIDTH-1:0] store_word
);

    // Wait states last until the counter reaches the RAM latency
    localparam int CNT_WIDTH = $clog2(RAM_LATENCY + 1);
    localparam logic [CNT_WIDTH-1:0] WAIT_LAST = CNT_WIDTH'(RAM_LATENCY);

    typedef enum logic [2:0] {
        idle,
        load_wait,
        load_done,
        store_wait,
        store_write
    } state_t;

    state_t               state;
    mem_pkg::access_t     req_access;
    logic                 req_is_load;
    logic                 accept;
    logic [CNT_WIDTH-1:0] wait_cnt;

    // Read has priority when both enables are high
    always_comb begin
        req_access = mem_pkg::NOP;
        if (read_en) begin
            case (funct3)
                mem_pkg::FUNCT3_B:  req_access = mem_pkg::LB;
                mem_pkg::FUNCT3_H:  req_access = mem_pkg::LH;
                mem_pkg::FUNCT3_W:  req_access = mem_pkg::LW;
                mem_pkg::FUNCT3_BU: req_access = mem_pkg::LBU;
                mem_pkg::FUNCT3_HU: req_access = mem_pkg::LHU;
                default:            req_access = mem_pkg::NOP;
            endcase
        end else if (write_en) begin
            case (funct3)
                mem_pkg::FUNCT3_B: req_access = mem_pkg::SB;
                mem_pkg::FUNCT3_H: req_access = mem_pkg::SH;
                mem_pkg::FUNCT3_W: req_access = mem_pkg::SW;
                default:           req_access = mem_pkg::NOP;
            endcase
        end
    end

    assign req_is_load = req_access inside {mem_pkg::LB, mem_pkg::LH, mem_pkg::LW,
                                            mem_pkg::LBU, mem_pkg::LHU};
    assign accept      = (state == idle) && (req_access != mem_pkg::NOP);
    assign ready       = (state == idle);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= idle;
            access    <= mem_pkg::NOP;
            ram_read  <= 1'b0;
            ram_write <= 1'b0;
            data_out  <= '0;
            wait_cnt  <= '0;
        end else begin
            case (state)
                idle: begin
                    if (accept) begin
                        access   <= req_access;
                        wait_cnt <= '0;
                        // Full word stores skip the read of the old word
                        if (req_access == mem_pkg::SW) begin
                            state <= store_write;
                        end else begin
                            ram_read <= 1'b1;
                            state    <= req_is_load ? load_wait : store_wait;
                        end
                    end
                end
                load_wait, store_wait: begin
                    ram_read <= 1'b0;
                    if (wait_cnt == WAIT_LAST) begin
                        state <= (state == load_wait) ? load_done : store_write;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                load_done: begin
                    data_out <= aligned;
                    state    <= idle;
                end
                store_write: begin
                    // First cycle issues the write, second lets the RAM take it
                    if (!ram_write) begin
                        ram_write <= 1'b1;
                    end else begin
                        ram_write <= 1'b0;
                        state     <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Request payload and write data
    always_ff @(posedge clk) begin
        if (accept) begin
            ram_index  <= address[ADDR_WIDTH-1:2];
            lane       <= address[1:0];
            store_word <= data_in;
        end
        if (state == store_write && !ram_write) begin
            ram_wdata <= merged;
        end
    end

endmodule

`default_nettype wire

/* source/store_merge.sv */
`default_nettype none

module store_merge (
    input  mem_pkg::access_t                         access,
    input  logic [1:0]                               lane,
    input  logic [mem_pkg::DEFAULT_DATA_WIDTH-1:0]   old_word,
    input  logic [mem_pkg::DEFAULT_DATA_WIDTH-1:0]   store_data,
    output logic [mem_pkg::DEFAULT_DATA_WIDTH-1:0]   merged
);

    localparam int WIDTH = mem_pkg::DEFAULT_DATA_WIDTH;

    logic [3:0]       byte_en;
    logic [WIDTH-1:0] lane_data;

    // Byte enables for the addressed lanes
    always_comb begin
        case (access)
            mem_pkg::SB: begin
                byte_en = 4'b0001 << lane;
            end
            mem_pkg::SH: begin
                byte_en = lane[1] ? 4'b1100 : 4'b0011;
            end
            mem_pkg::SW: begin
                byte_en = 4'b1111;
            end
            default: begin
                byte_en = 4'b0000;
            end
        endcase
    end

    // Replicate the low store bits so every lane sees its own copy
    always_comb begin
        case (access)
            mem_pkg::SB: lane_data = {4{store_data[7:0]}};
            mem_pkg::SH: lane_data = {2{store_data[15:0]}};
            default:     lane_data = store_data;
        endcase
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[b*8 +: 8] = byte_en[b] ? lane_data[b*8 +: 8] : old_word[b*8 +: 8];
        end
    end

endmodule

`default_nettype wire

/* source/load_align.sv */
`default_nettype none

module load_align (
    input  mem_pkg::access_t                         access,
    input  logic [1:0]                               lane,
    input  logic [mem_pkg::DEFAULT_DATA_WIDTH-1:0]   word,
    output logic [mem_pkg::DEFAULT_DATA_WIDTH-1:0]   result
);

    localparam int WIDTH = mem_pkg::DEFAULT_DATA_WIDTH;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // Byte lane from both address bits, halfword lane from bit 1 only
    assign byte_sel = word[lane*8 +: 8];
    assign half_sel = word[lane[1]*16 +: 16];

    always_comb begin
        case (access)
            mem_pkg::LB: begin
                result = {{(WIDTH-8){byte_sel[7]}}, byte_sel};
            end
            mem_pkg::LBU: begin
                result = {{(WIDTH-8){1'b0}}, byte_sel};
            end
            mem_pkg::LH: begin
                result = {{(WIDTH-16){half_sel[15]}}, half_sel};
            end
            mem_pkg::LHU: begin
                result = {{(WIDTH-16){1'b0}}, half_sel};
            end
            mem_pkg::LW: begin
                result = word;
            end
            // Stores never use this result
            default: begin
                result = word;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/word_ram.sv */
`default_nettype none

module word_ram #(
    parameter int DATA_WIDTH   = 32,
    parameter int MEMORY_DEPTH = 1024,
    parameter int RAM_LATENCY  = 2
) (
    input  logic                            clk,
    input  logic                            ram_read,
    input  logic                            ram_write,
    input  logic [$clog2(MEMORY_DEPTH)-1:0] ram_index,
    input  logic [DATA_WIDTH-1:0]           ram_wdata,
    output logic [DATA_WIDTH-1:0]           ram_rdata
);

    // Word storage, contents undefined until written
    logic [DATA_WIDTH-1:0] mem [MEMORY_DEPTH];

    // Read data delay line, stage 0 is loaded by the read itself
    logic [DATA_WIDTH-1:0] read_pipe [RAM_LATENCY];

    // Index is only log2(depth) bits wide, so accesses wrap around the array
    always_ff @(posedge clk) begin
        if (ram_write) begin
            mem[ram_index] <= ram_wdata;
        end
    end

    // Read before write when both hit the same edge
    always_ff @(posedge clk) begin
        if (ram_read) begin
            read_pipe[0] <= mem[ram_index];
        end
    end

    // Later stages shift every cycle, so a finished read stays on the output
    // until the next one arrives
    always_ff @(posedge clk) begin
        for (int i = 1; i < RAM_LATENCY; i++) begin
            read_pipe[i] <= read_pipe[i-1];
        end
    end

    assign ram_rdata = read_pipe[RAM_LATENCY-1];

endmodule

`default_nettype wire

/* source/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // Word and byte address widths used when the top level is not overridden
    localparam int DEFAULT_DATA_WIDTH = 32;
    localparam int DEFAULT_ADDR_WIDTH = 32;

    // RV32 load/store funct3 encodings
    localparam logic [2:0] FUNCT3_B  = 3'b000;
    localparam logic [2:0] FUNCT3_H  = 3'b001;
    localparam logic [2:0] FUNCT3_W  = 3'b010;
    localparam logic [2:0] FUNCT3_BU = 3'b100;
    localparam logic [2:0] FUNCT3_HU = 3'b101;

    // Access kind after combining funct3 with the request direction
    typedef enum logic [3:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW,
        // Reserved code or no request
        NOP
    } access_t;

endpackage

`default_nettype wire
